// File: src/dcachePkg.sv
package dcachePkg;

  // One processor word, used for both data and addresses
  typedef logic [31:0] wordT;

  // Low address fields below the set index
  localparam int byteOffBits  = 2;
  localparam int blockOffBits = 1;

  // Miss handler sequence
  // Victim write-back is skipped when the victim line is clean
  typedef enum logic [2:0] {
    msIdle,
    msWriteBack0,
    msWriteBack1,
    msFill0,
    msFill1,
    msDone
  } missStateT;

  // Flush engine sequence
  typedef enum logic [2:0] {
    fsIdle,
    fsCheck,
    fsWrite0,
    fsWrite1,
    fsNext,
    fsFlushed
  } flushStateT;

endpackage

// File: src/cacheArray.sv
`timescale 1ns/1ps

module cacheArray #(
  parameter int numSets = 8,
  localparam int idxBits = $clog2(numSets),
  localparam int tagBits = 32 - idxBits - dcachePkg::blockOffBits - dcachePkg::byteOffBits
) (
  input  logic                   clk,
  input  logic                   arstN,
  input  dcachePkg::wordT        lookupAddr,
  input  logic                   writeEn,
  input  dcachePkg::wordT        writeData,
  input  logic                   fillEn,
  input  logic                   fillWord,
  input  dcachePkg::wordT        fillData,
  input  logic                   cleanEn,
  input  logic [idxBits-1:0]     cleanIndex,
  output logic                   hit,
  output dcachePkg::wordT        readData,
  output logic                   victimDirty,
  output logic [tagBits-1:0]     victimTag,
  output dcachePkg::wordT        victimData0,
  output dcachePkg::wordT        victimData1,
  input  logic [idxBits-1:0]     probeIndex,
  output logic                   probeDirty,
  output logic [tagBits-1:0]     probeTag,
  output dcachePkg::wordT        probeData0,
  output dcachePkg::wordT        probeData1
);

  localparam int lowBits = dcachePkg::blockOffBits + dcachePkg::byteOffBits;

  logic [tagBits-1:0]    tagMem   [numSets];
  dcachePkg::wordT       data0Mem [numSets];
  dcachePkg::wordT       data1Mem [numSets];
  logic [numSets-1:0]    validBits;
  logic [numSets-1:0]    dirtyBits;

  logic [idxBits-1:0]    lookupIndex;
  logic [tagBits-1:0]    lookupTag;
  logic                  lookupWord;

  // Split {tag, index, block offset, byte offset}
  assign lookupIndex = lookupAddr[lowBits +: idxBits];
  assign lookupTag   = lookupAddr[31 -: tagBits];
  assign lookupWord  = lookupAddr[dcachePkg::byteOffBits];

  assign hit      = validBits[lookupIndex] && (tagMem[lookupIndex] == lookupTag);
  assign readData = lookupWord ? data1Mem[lookupIndex] : data0Mem[lookupIndex];

  // Line currently sitting in the looked-up set
  assign victimDirty = validBits[lookupIndex] && dirtyBits[lookupIndex];
  assign victimTag   = tagMem[lookupIndex];
  assign victimData0 = data0Mem[lookupIndex];
  assign victimData1 = data1Mem[lookupIndex];

  // Probe port for the flush walk
  assign probeDirty = validBits[probeIndex] && dirtyBits[probeIndex];
  assign probeTag   = tagMem[probeIndex];
  assign probeData0 = data0Mem[probeIndex];
  assign probeData1 = data1Mem[probeIndex];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else begin
      // Line only turns valid once its second word lands
      if (fillEn) begin
        validBits[lookupIndex] <= fillWord;
        dirtyBits[lookupIndex] <= 1'b0;
      end else if (writeEn) begin
        dirtyBits[lookupIndex] <= 1'b1;
      end
      if (cleanEn) begin
        dirtyBits[cleanIndex] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fillEn) begin
      tagMem[lookupIndex] <= lookupTag;
      if (fillWord) begin
        data1Mem[lookupIndex] <= fillData;
      end else begin
        data0Mem[lookupIndex] <= fillData;
      end
    end else if (writeEn) begin
      if (lookupWord) begin
        data1Mem[lookupIndex] <= writeData;
      end else begin
        data0Mem[lookupIndex] <= writeData;
      end
    end
  end

endmodule

// File: src/missHandler.sv
`timescale 1ns/1ps

module missHandler #(
  parameter int numSets = 8,
  localparam int idxBits = $clog2(numSets),
  localparam int tagBits = 32 - idxBits - dcachePkg::blockOffBits - dcachePkg::byteOffBits
) (
  input  logic                clk,
  input  logic                arstN,
  input  logic                dmemREN,
  input  logic                dmemWEN,
  input  dcachePkg::wordT     dmemaddr,
  input  logic                hit,
  input  logic                victimDirty,
  input  logic [tagBits-1:0]  victimTag,
  input  dcachePkg::wordT     victimData0,
  input  dcachePkg::wordT     victimData1,
  input  logic                busGnt,
  input  logic                dwait,
  input  dcachePkg::wordT     dload,
  output logic                busReq,
  output logic                busREN,
  output logic                busWEN,
  output dcachePkg::wordT     busAddr,
  output dcachePkg::wordT     busStore,
  output logic                fillEn,
  output logic                fillWord,
  output logic                cleanEn,
  output logic                idle,
  output dcachePkg::wordT     fillData
);

  localparam int lowBits = dcachePkg::blockOffBits + dcachePkg::byteOffBits;

  dcachePkg::missStateT state;
  dcachePkg::missStateT nextState;

  logic [idxBits-1:0]                     setIndex;
  logic [tagBits-1:0]                     reqTag;
  logic [dcachePkg::blockOffBits-1:0]     wordSel;
  logic                                   xferDone;
  logic                                   missSeen;

  assign setIndex = dmemaddr[lowBits +: idxBits];
  assign reqTag   = dmemaddr[31 -: tagBits];
  assign missSeen = (dmemREN || dmemWEN) && !hit;

  // One word moves on each granted edge without wait
  assign xferDone = busGnt && !dwait;

  assign idle   = (state == dcachePkg::msIdle);
  assign busWEN = (state == dcachePkg::msWriteBack0) || (state == dcachePkg::msWriteBack1);
  assign busREN = (state == dcachePkg::msFill0) || (state == dcachePkg::msFill1);
  assign busReq = busWEN || busREN;

  // Second word of the block in the *1 states
  assign wordSel = ((state == dcachePkg::msWriteBack1) || (state == dcachePkg::msFill1))
                   ? 1'b1 : 1'b0;

  // Write-back goes to the old tag and fill to the requested one
  always_comb begin
    if (busWEN) begin
      busAddr = {victimTag, setIndex, wordSel, {dcachePkg::byteOffBits{1'b0}}};
    end else begin
      busAddr = {reqTag, setIndex, wordSel, {dcachePkg::byteOffBits{1'b0}}};
    end
  end

  assign busStore = wordSel[0] ? victimData1 : victimData0;

  assign fillData = dload;
  assign fillWord = (state == dcachePkg::msFill1);
  assign fillEn   = busREN && xferDone;
  assign cleanEn  = (state == dcachePkg::msWriteBack1) && xferDone;

  always_comb begin
    nextState = state;
    case (state)
      dcachePkg::msIdle: begin
        if (missSeen) begin
          nextState = victimDirty ? dcachePkg::msWriteBack0 : dcachePkg::msFill0;
        end
      end
      dcachePkg::msWriteBack0: begin
        if (xferDone) begin
          nextState = dcachePkg::msWriteBack1;
        end
      end
      dcachePkg::msWriteBack1: begin
        if (xferDone) begin
          nextState = dcachePkg::msFill0;
        end
      end
      dcachePkg::msFill0: begin
        if (xferDone) begin
          nextState = dcachePkg::msFill1;
        end
      end
      dcachePkg::msFill1: begin
        if (xferDone) begin
          nextState = dcachePkg::msDone;
        end
      end
      // Bus released here so the hit path takes over next cycle
      dcachePkg::msDone: nextState = dcachePkg::msIdle;
      default: nextState = dcachePkg::msIdle;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= dcachePkg::msIdle;
    end else begin
      state <= nextState;
    end
  end

endmodule

// File: src/flushEngine.sv
`timescale 1ns/1ps

module flushEngine #(
  parameter int numSets = 8,
  localparam int idxBits = $clog2(numSets),
  localparam int tagBits = 32 - idxBits - dcachePkg::blockOffBits - dcachePkg::byteOffBits
) (
  input  logic                clk,
  input  logic                arstN,
  input  logic                halt,
  input  logic                missIdle,
  input  logic                probeDirty,
  input  logic [tagBits-1:0]  probeTag,
  input  dcachePkg::wordT     probeData0,
  input  dcachePkg::wordT     probeData1,
  input  logic                flushGnt,
  input  logic                dwait,
  output logic [idxBits-1:0]  probeIndex,
  output logic                flushReq,
  output logic                flushWEN,
  output dcachePkg::wordT     flushAddr,
  output dcachePkg::wordT     flushStore,
  output logic                cleanEn,
  output logic                flushed
);

  localparam logic [idxBits-1:0] lastIndex = idxBits'(numSets - 1);

  dcachePkg::flushStateT state;
  logic [idxBits-1:0]    setCount;
  logic                  secondWord;
  logic                  xferDone;

  assign probeIndex = setCount;
  assign secondWord = (state == dcachePkg::fsWrite1);
  assign flushWEN   = (state == dcachePkg::fsWrite0) || secondWord;

  // Bus only asked for while halted and no miss is running
  assign flushReq = flushWEN && halt && missIdle;
  assign xferDone = flushGnt && !dwait;

  assign flushAddr  = {probeTag, setCount, secondWord, {dcachePkg::byteOffBits{1'b0}}};
  assign flushStore = secondWord ? probeData1 : probeData0;
  assign cleanEn    = secondWord && xferDone;
  assign flushed    = (state == dcachePkg::fsFlushed);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state    <= dcachePkg::fsIdle;
      setCount <= '0;
    end else begin
      case (state)
        dcachePkg::fsIdle: begin
          if (halt && missIdle) begin
            state <= dcachePkg::fsCheck;
          end
        end
        // Clean or invalid sets cost no bus traffic
        dcachePkg::fsCheck: begin
          state <= probeDirty ? dcachePkg::fsWrite0 : dcachePkg::fsNext;
        end
        dcachePkg::fsWrite0: begin
          if (xferDone) begin
            state <= dcachePkg::fsWrite1;
          end
        end
        dcachePkg::fsWrite1: begin
          if (xferDone) begin
            state <= dcachePkg::fsNext;
          end
        end
        dcachePkg::fsNext: begin
          if (setCount == lastIndex) begin
            state <= dcachePkg::fsFlushed;
          end else begin
            setCount <= setCount + 1'b1;
            state    <= dcachePkg::fsCheck;
          end
        end
        // Stays here until reset
        dcachePkg::fsFlushed: state <= dcachePkg::fsFlushed;
        default: state <= dcachePkg::fsIdle;
      endcase
    end
  end

endmodule

// File: src/memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
  input  logic             clk,
  input  logic             arstN,
  input  logic             busReq,
  input  logic             flushReq,
  input  logic             busREN,
  input  logic             busWEN,
  input  dcachePkg::wordT  busAddr,
  input  dcachePkg::wordT  busStore,
  input  logic             flushWEN,
  input  dcachePkg::wordT  flushAddr,
  input  dcachePkg::wordT  flushStore,
  output logic             busGnt,
  output logic             flushGnt,
  output logic             dREN,
  output logic             dWEN,
  output dcachePkg::wordT  daddr,
  output dcachePkg::wordT  dstore
);

  // Current owner kept while its request stays up
  logic ownMiss;
  logic ownFlush;

  // Miss handler wins unless the flush engine already holds the bus
  assign busGnt   = busReq && !ownFlush;
  assign flushGnt = flushReq && !ownMiss && !busGnt;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ownMiss  <= 1'b0;
      ownFlush <= 1'b0;
    end else begin
      ownMiss  <= busGnt;
      ownFlush <= flushGnt;
    end
  end

  // Idle bus drives zeros and the flush side never reads
  assign dREN   = busGnt && busREN;
  assign dWEN   = (busGnt && busWEN) || (flushGnt && flushWEN);
  assign daddr  = busGnt ? busAddr : (flushGnt ? flushAddr : '0);
  assign dstore = busGnt ? busStore : (flushGnt ? flushStore : '0);

endmodule

// File: src/dcache.sv
`timescale 1ns/1ps

module dcache #(
  parameter int numSets = 8,
  localparam int idxBits = $clog2(numSets),
  localparam int tagBits = 32 - idxBits - dcachePkg::blockOffBits - dcachePkg::byteOffBits
) (
  input  logic             clk,
  input  logic             arstN,
  input  logic             halt,
  input  logic             dmemREN,
  input  logic             dmemWEN,
  input  dcachePkg::wordT  dmemaddr,
  input  dcachePkg::wordT  dmemstore,
  input  dcachePkg::wordT  dload,
  input  logic             dwait,
  output logic             dhit,
  output logic             flushed,
  output logic             dREN,
  output logic             dWEN,
  output dcachePkg::wordT  dmemload,
  output dcachePkg::wordT  daddr,
  output dcachePkg::wordT  dstore
);

  localparam int lowBits = dcachePkg::blockOffBits + dcachePkg::byteOffBits;

  logic arrayHit, arrayWriteEn, victimDirty, probeDirty;
  logic fillEn, fillWord, missCleanEn, flushCleanEn, arrayCleanEn, missIdle;
  logic busReq, busREN, busWEN, busGnt, flushReq, flushWEN, flushGnt;
  logic [tagBits-1:0] victimTag;
  logic [tagBits-1:0] probeTag;
  logic [idxBits-1:0] probeIndex;
  logic [idxBits-1:0] cleanIndex;
  dcachePkg::wordT victimData0, victimData1, probeData0, probeData1;
  dcachePkg::wordT fillData, busAddr, busStore, flushAddr, flushStore;

  // Hit only counts once the miss handler has let go
  assign dhit         = (dmemREN || dmemWEN) && arrayHit && missIdle;
  assign arrayWriteEn = dmemWEN && dhit;

  // Dirty clear follows the bus owner
  assign arrayCleanEn = busGnt ? missCleanEn : (flushGnt && flushCleanEn);
  assign cleanIndex   = flushGnt ? probeIndex : dmemaddr[lowBits +: idxBits];

  cacheArray #(.numSets(numSets)) array (
    .clk(clk), .arstN(arstN), .lookupAddr(dmemaddr), .writeEn(arrayWriteEn),
    .writeData(dmemstore), .fillEn(fillEn), .fillWord(fillWord), .fillData(fillData),
    .cleanEn(arrayCleanEn), .cleanIndex(cleanIndex), .hit(arrayHit), .readData(dmemload),
    .victimDirty(victimDirty), .victimTag(victimTag), .victimData0(victimData0),
    .victimData1(victimData1), .probeIndex(probeIndex), .probeDirty(probeDirty),
    .probeTag(probeTag), .probeData0(probeData0), .probeData1(probeData1)
  );

  missHandler #(.numSets(numSets)) miss (
    .clk(clk), .arstN(arstN), .dmemREN(dmemREN), .dmemWEN(dmemWEN), .dmemaddr(dmemaddr),
    .hit(arrayHit), .victimDirty(victimDirty), .victimTag(victimTag),
    .victimData0(victimData0), .victimData1(victimData1), .busGnt(busGnt), .dwait(dwait),
    .dload(dload), .busReq(busReq), .busREN(busREN), .busWEN(busWEN), .busAddr(busAddr),
    .busStore(busStore), .fillEn(fillEn), .fillWord(fillWord), .cleanEn(missCleanEn),
    .idle(missIdle), .fillData(fillData)
  );

  flushEngine #(.numSets(numSets)) flush (
    .clk(clk), .arstN(arstN), .halt(halt), .missIdle(missIdle), .probeDirty(probeDirty),
    .probeTag(probeTag), .probeData0(probeData0), .probeData1(probeData1),
    .flushGnt(flushGnt), .dwait(dwait), .probeIndex(probeIndex), .flushReq(flushReq),
    .flushWEN(flushWEN), .flushAddr(flushAddr), .flushStore(flushStore),
    .cleanEn(flushCleanEn), .flushed(flushed)
  );

  memArbiter arbiter (
    .clk(clk), .arstN(arstN), .busReq(busReq), .flushReq(flushReq), .busREN(busREN),
    .busWEN(busWEN), .busAddr(busAddr), .busStore(busStore), .flushWEN(flushWEN),
    .flushAddr(flushAddr), .flushStore(flushStore), .busGnt(busGnt), .flushGnt(flushGnt),
    .dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore)
  );

endmodule

// File: verif/dcache_assertions.sv
`timescale 1ns/1ps

module dcacheAssertions (
  input logic            clk,
  input logic            arstN,
  input logic            dREN,
  input logic            dWEN,
  input logic            dwait,
  input logic            dhit,
  input logic            flushed,
  input dcachePkg::wordT daddr,
  input dcachePkg::wordT dstore
);

  // One direction on the bus at a time
  assert property (@(posedge clk) disable iff (!arstN) !(dREN && dWEN))
    else $error("dREN and dWEN are high together");

  // A stalled transfer holds direction, address and data
  assert property (@(posedge clk) disable iff (!arstN)
    (dwait && (dREN || dWEN)) |=> ($stable(dREN) && $stable(dWEN) && $stable(daddr)
                                    && $stable(dstore)))
    else $error("Bus outputs changed while dwait was high");

  assert property (@(posedge clk) !arstN |-> !dhit)
    else $error("dhit is high during reset");

  // Flush completion is sticky
  assert property (@(posedge clk) disable iff (!arstN) !$fell(flushed))
    else $error("flushed fell without a reset");

endmodule

bind dcache dcacheAssertions assertions (
  .clk(clk), .arstN(arstN), .dREN(dREN), .dWEN(dWEN), .dwait(dwait), .dhit(dhit),
  .flushed(flushed), .daddr(daddr), .dstore(dstore)
);

// File: verif/dcacheTb.sv
`timescale 1ns/1ps

module dcacheTb;

  localparam int maxOps = 64;

  logic clk = 1'b0;
  logic arstN;
  logic halt;
  logic dmemREN;
  logic dmemWEN;
  dcachePkg::wordT dmemaddr;
  dcachePkg::wordT dmemstore;
  dcachePkg::wordT dload = '0;
  logic dwait = 1'b1;
  logic dhit;
  logic flushed;
  logic dREN;
  logic dWEN;
  dcachePkg::wordT dmemload;
  dcachePkg::wordT daddr;
  dcachePkg::wordT dstore;

  // Four words per operation in file order
  dcachePkg::wordT opData [256];
  dcachePkg::wordT memWords [dcachePkg::wordT];
  dcachePkg::wordT refMem [dcachePkg::wordT];

  // Shadow of tag, valid and dirty per set
  logic [25:0] tagS [8];
  logic [7:0]  validS;
  logic [7:0]  dirtyS;

  int          numOps;
  int          readCount = 0;
  int          writeCount = 0;
  logic        opsLoaded = 1'b0;
  logic [15:0] lfsr = 16'd42430;
  logic        pending = 1'b0;
  logic [1:0]  waitLeft = 2'd0;

  dcache dut (
    .clk(clk), .arstN(arstN), .halt(halt), .dmemREN(dmemREN), .dmemWEN(dmemWEN),
    .dmemaddr(dmemaddr), .dmemstore(dmemstore), .dload(dload), .dwait(dwait),
    .dhit(dhit), .flushed(flushed), .dREN(dREN), .dWEN(dWEN), .dmemload(dmemload),
    .daddr(daddr), .dstore(dstore)
  );

  always #10 clk = ~clk;

  // Galois form with taps at 16, 14, 13 and 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Untouched memory reads back its own address
  function automatic dcachePkg::wordT memValue(input dcachePkg::wordT a);
    if (memWords.exists(a)) begin
      return memWords[a];
    end
    return a;
  endfunction

  function automatic dcachePkg::wordT refValue(input dcachePkg::wordT a);
    if (refMem.exists(a)) begin
      return refMem[a];
    end
    return a;
  endfunction

  task automatic checkValue(input string name, input dcachePkg::wordT got,
                            input dcachePkg::wordT expected);
    if (got !== expected) begin
      $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, expected);
      $display("ERRORS FOUND");
      $fatal(1, "Check on %s failed", name);
    end
  endtask

  // Memory model with 0 to 3 wait cycles before each word
  always @(negedge clk) begin
    if (!arstN || !(dREN || dWEN)) begin
      dwait   <= 1'b1;
      pending = 1'b0;
    end else begin
      // dwait low here means the last posedge finished a word
      if (!pending || !dwait) begin
        pending = 1'b1;
        repeat (2) begin
          waitLeft = {waitLeft[0], lfsr[0]};
          lfsr = lfsrNext(lfsr);
        end
      end else if (waitLeft != 2'd0) begin
        waitLeft = waitLeft - 2'd1;
      end
      dwait <= (waitLeft != 2'd0);
      if (waitLeft == 2'd0) begin
        if (dWEN) begin
          checkValue("dstore", dstore, refValue(daddr));
          checkValue("daddr word", {31'd0, daddr[2]}, {31'd0, writeCount[0]});
          // Write-back targets the tag the line holds in the shadow
          checkValue("daddr tag", {daddr[31:6], 6'd0}, {tagS[daddr[5:3]], 6'd0});
          if (!halt) begin
            checkValue("daddr set", {26'd0, daddr[5:3], 3'd0}, {26'd0, dmemaddr[5:3], 3'd0});
          end
          memWords[daddr] = dstore;
          writeCount = writeCount + 1;
        end else begin
          checkValue("daddr block", {daddr[31:3], 3'd0}, {dmemaddr[31:3], 3'd0});
          checkValue("daddr word", {31'd0, daddr[2]}, {31'd0, readCount[0]});
          dload <= memValue(daddr);
          readCount = readCount + 1;
        end
      end
    end
  end

  task automatic runAccess(input logic isWrite, input dcachePkg::wordT addr,
                           input dcachePkg::wordT wdata, input dcachePkg::wordT expLoad);
    logic [2:0] setIdx;
    logic       wasHit;
    logic       victimDirty;
    int         reads0;
    int         writes0;
    setIdx = addr[5:3];
    wasHit = validS[setIdx] && (tagS[setIdx] == addr[31:6]);
    victimDirty = !wasHit && validS[setIdx] && dirtyS[setIdx];
    reads0 = readCount;
    writes0 = writeCount;
    dmemaddr = addr;
    dmemstore = wdata;
    dmemREN = !isWrite;
    dmemWEN = isWrite;
    #5;
    while (!dhit) begin
      @(negedge clk);
      #5;
    end
    checkValue("bus reads", dcachePkg::wordT'(readCount - reads0), wasHit ? 32'd0 : 32'd2);
    checkValue("bus writes", dcachePkg::wordT'(writeCount - writes0),
               victimDirty ? 32'd2 : 32'd0);
    if (isWrite) begin
      refMem[addr] = wdata;
    end else begin
      checkValue("dmemload", dmemload, expLoad);
    end
    dirtyS[setIdx] = isWrite || (wasHit && dirtyS[setIdx]);
    validS[setIdx] = 1'b1;
    tagS[setIdx] = addr[31:6];
    @(negedge clk);
    dmemREN = 1'b0;
    dmemWEN = 1'b0;
  endtask

  task automatic runFlush();
    int writes0;
    int dirtySets;
    writes0 = writeCount;
    dirtySets = $countones(validS & dirtyS);
    halt = 1'b1;
    #5;
    while (!flushed) begin
      @(negedge clk);
      #5;
    end
    // Only dirty lines go back to memory
    checkValue("flush writes", dcachePkg::wordT'(writeCount - writes0),
               dcachePkg::wordT'(2 * dirtySets));
    dirtyS = '0;
    foreach (refMem[a]) begin
      checkValue($sformatf("mem[%h]", a), memValue(a), refMem[a]);
    end
    @(negedge clk);
  endtask

  initial begin
    logic [7:0] opPos;
    arstN = 1'b0;
    halt = 1'b0;
    dmemREN = 1'b0;
    dmemWEN = 1'b0;
    dmemaddr = '0;
    dmemstore = '0;
    validS = '0;
    dirtyS = '0;
    $readmemh("verif/dcacheInput.txt", opData);
    numOps = 0;
    opPos = 8'd0;
    while (opData[opPos] != 32'd3 && numOps < maxOps) begin
      numOps = numOps + 1;
      opPos = opPos + 8'd4;
    end
    opsLoaded = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    opPos = 8'd0;
    repeat (numOps) begin
      if (opData[opPos] == 32'd2) begin
        runFlush();
      end else begin
        runAccess(opData[opPos] == 32'd1, opData[opPos + 8'd1], opData[opPos + 8'd2],
                  opData[opPos + 8'd3]);
      end
      opPos = opPos + 8'd4;
    end
    $display("NO ERRORS");
    $finish;
  end

  // Watchdog sized from the operation count
  initial begin
    wait (opsLoaded);
    repeat (numOps * 40 + 200) @(posedge clk);
    $display("Timeout: the operations did not finish within %0d cycles", numOps * 40 + 200);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation timed out");
  end

endmodule

// File: verif/dcacheInput.txt
// Columns: kind (0 read, 1 write, 2 halt, 3 end), byte address, store data, expected load
// Memory never written reads back its own address
0 00000100 00000000 00000100
0 00000104 00000000 00000104
1 00000104 11112222 00000000
0 00000104 00000000 11112222
0 00000100 00000000 00000100
1 00000208 33334444 00000000
0 00000208 00000000 33334444
0 0000020C 00000000 0000020C
0 00000300 00000000 00000300
0 00000104 00000000 11112222
1 00000100 55556666 00000000
1 00000348 77778888 00000000
0 0000034C 00000000 0000034C
0 00000208 00000000 33334444
1 0000001C 9999AAAA 00000000
1 00000018 BBBBCCCC 00000000
0 0000001C 00000000 9999AAAA
0 00000018 00000000 BBBBCCCC
0 00000420 00000000 00000420
1 00000424 DDDDEEEE 00000000
0 00000028 00000000 00000028
0 00000038 00000000 00000038
1 0000103C 0F0F0F0F 00000000
0 00001038 00000000 00001038
0 00000104 00000000 11112222
0 00000100 00000000 55556666
1 00000104 12345678 00000000
0 00000104 00000000 12345678
0 0000002C 00000000 0000002C
2 00000000 00000000 00000000
3 00000000 00000000 00000000

// File: all.f
src/dcachePkg.sv
src/cacheArray.sv
src/missHandler.sv
src/flushEngine.sv
src/memArbiter.sv
src/dcache.sv
verif/dcache_assertions.sv
verif/dcacheTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module dcacheTb -f all.f

output=$(./obj_dir/VdcacheTb 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1
